// File: Makefile
SRCS := $(shell cat vlog.f)

.PHONY: run clean

run: obj_dir/Vtb_lsu_subsys
	@out="$$(./obj_dir/Vtb_lsu_subsys)"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

obj_dir/Vtb_lsu_subsys: vlog.f $(SRCS)
	verilator --binary --timing --assert -f vlog.f --top-module tb_lsu_subsys

clean:
	rm -rf obj_dir

// File: dv/tb_lsu_subsys.sv
`timescale 1ns/1ps

module tb_lsu_subsys;
    import lsu_pkg::*;

    logic     clk;
    logic     rst_n;
    logic     prev_valid;
    lsu_req_t req;
    logic     this_ready;
    logic     this_valid;
    logic     next_ready;
    lsu_rsp_t rsp;

    // byte image of the 256-word memory
    logic [7:0] mirror [1024];
    int         errors;
    int         checks;
    bit         timed_out;
    lsu_req_t   r;

    lsu_subsys #(
        .mem_words(256),
        .mem_wait (3)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .prev_valid(prev_valid),
        .req       (req),
        .this_ready(this_ready),
        .this_valid(this_valid),
        .next_ready(next_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic lsu_req_t make_req(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [31:0] addr, input logic [31:0] wdata);
        lsu_req_t q;
        q.inst        = $urandom;
        q.inst[14:12] = f3;
        q.inst[6:0]   = opc;
        q.addr        = addr;
        q.wdata       = wdata;
        return q;
    endfunction

    function automatic lsu_req_t random_req();
        lsu_req_t q;
        int       kind;
        q     = make_req(7'b0110011, 3'($urandom % 8), $urandom, $urandom);
        kind  = $urandom % 10;
        if (kind < 4) begin
            q.inst[6:0] = opc_load;
        end else if (kind < 8) begin
            q.inst[6:0] = opc_store;
        end
        kind = $urandom % 10;
        if (kind < 8) begin
            q.addr = $urandom % 1024;
        end else if (kind < 9) begin
            q.addr = 32'd1024 + ($urandom % 1024);
        end
        return q;
    endfunction

    // expected result, and store effect on the mirror
    task automatic model_access(input lsu_req_t q, output logic [31:0] exp_data,
                                output logic exp_err);
        logic [2:0]  f3;
        logic [31:0] val;
        logic [9:0]  ba;
        int          first;
        int          nbytes;
        bit          sign_ext;
        bit          in_range;
        f3       = q.inst[14:12];
        first    = int'(q.addr[1:0]);
        in_range = (q.addr < 32'd1024);
        sign_ext = (f3 == f3_b) || (f3 == f3_h);
        exp_data = '0;
        exp_err  = 1'b0;
        if (q.inst[6:0] == opc_load) begin
            case (f3)
                f3_b, f3_bu: nbytes = 1;
                f3_h, f3_hu: nbytes = 2;
                default:     nbytes = 4;
            endcase
            // an access that leaves its word is misaligned
            if (first + nbytes > 4 || !in_range) begin
                exp_err = 1'b1;
            end else begin
                val = '0;
                for (int i = 0; i < nbytes; i++) begin
                    ba = q.addr[9:0] + 10'(i);
                    val[8*i +: 8] = mirror[ba];
                end
                if (sign_ext && val[8*nbytes-1]) begin
                    for (int i = nbytes; i < 4; i++) begin
                        val[8*i +: 8] = 8'hff;
                    end
                end
                exp_data = val;
            end
        end else if (q.inst[6:0] == opc_store) begin
            case (f3)
                f3_b:    nbytes = 1;
                f3_h:    nbytes = 2;
                f3_w:    nbytes = 4;
                default: nbytes = 0;
            endcase
            if (first + nbytes > 4 || !in_range) begin
                exp_err = 1'b1;
            end else begin
                for (int i = 0; i < nbytes; i++) begin
                    ba = q.addr[9:0] + 10'(i);
                    mirror[ba] = q.wdata[8*i +: 8];
                end
            end
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic run_op(input lsu_req_t q);
        logic [31:0] exp_data;
        logic        exp_err;
        lsu_rsp_t    held;
        bit          seen;
        int          cnt;
        if (timed_out) begin
            return;
        end
        model_access(q, exp_data, exp_err);
        prev_valid = 1'b1;
        req        = q;
        cnt        = 0;
        while (!this_ready) begin
            if (cnt == 200) begin
                $display("timeout: this_ready never rose to take a request");
                timed_out = 1'b1;
                return;
            end
            @(negedge clk);
            cnt++;
        end
        @(negedge clk);
        prev_valid = 1'b0;
        req        = make_req(7'($urandom), 3'($urandom), $urandom, $urandom);
        cnt        = 0;
        seen       = 1'b0;
        forever begin
            if (this_ready) begin
                $display("Error t=%0t this_ready got 1 expected 0", $time);
                errors++;
            end
            if (this_valid) begin
                if (!seen) begin
                    held = rsp;
                    seen = 1'b1;
                end else if (rsp !== held) begin
                    $display("Error t=%0t rsp got %h expected %h", $time, rsp, held);
                    errors++;
                end
            end
            next_ready = (($urandom % 4) != 0);
            if (this_valid && next_ready) begin
                break;
            end
            if (cnt == 200) begin
                $display("timeout: no result came back for the request");
                timed_out = 1'b1;
                return;
            end
            @(negedge clk);
            cnt++;
        end
        checks++;
        if (rsp.rdata !== exp_data) begin
            $display("Error t=%0t rsp.rdata got %h expected %h", $time, rsp.rdata, exp_data);
            errors++;
        end
        if (rsp.err !== exp_err) begin
            $display("Error t=%0t rsp.err got %b expected %b", $time, rsp.err, exp_err);
            errors++;
        end
        @(negedge clk);
        next_ready = 1'b0;
    endtask

    initial begin
        logic [31:0] base;
        void'($urandom(18));
        errors     = 0;
        checks     = 0;
        timed_out  = 1'b0;
        rst_n      = 1'b0;
        prev_valid = 1'b0;
        next_ready = 1'b0;
        req        = '0;
        for (int i = 0; i < 1024; i++) begin
            mirror[i] = 8'h00;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (this_valid !== 1'b0 || this_ready !== 1'b1) begin
            $display("Error t=%0t this_valid/this_ready got %b/%b expected 0/1",
                     $time, this_valid, this_ready);
            errors++;
        end

        // clear the memory so it matches the mirror
        for (int w = 0; w < 256; w++) begin
            run_op(make_req(opc_store, f3_w, 32'(w * 4), 32'h0));
        end

        // full word, then every width and offset read back
        for (int k = 0; k < 4; k++) begin
            base = ($urandom % 256) * 4;
            run_op(make_req(opc_store, f3_w, base, $urandom));
            for (int f = 0; f < 8; f++) begin
                for (int o = 0; o < 4; o++) begin
                    run_op(make_req(opc_load, 3'(f), base + 32'(o), 32'h0));
                end
            end
        end

        // partial lanes keep their neighbours
        for (int o = 0; o < 4; o++) begin
            base = ($urandom % 256) * 4;
            run_op(make_req(opc_store, f3_w, base, 32'h8899_aabb));
            run_op(make_req(opc_store, f3_b, base + 32'(o), $urandom));
            run_op(make_req(opc_store, f3_h, base + 32'(o), $urandom));
            run_op(make_req(opc_load, f3_w, base, 32'h0));
        end

        // just past the end of the memory
        run_op(make_req(opc_store, f3_w, 32'd1024, 32'hdead_beef));
        run_op(make_req(opc_load, f3_w, 32'd1024, 32'h0));
        // word 0 shares the low index bits
        run_op(make_req(opc_load, f3_w, 32'd0, 32'h0));

        for (int n = 0; n < 1500; n++) begin
            r = random_req();
            run_op(r);
        end

        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: rtl/axil_sram.sv
`timescale 1ns/1ps

module axil_sram #(
    parameter int mem_words = 256,
    parameter int mem_wait  = 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  lsu_pkg::axil_m_t axm,
    output lsu_pkg::axil_s_t axs
);
    import lsu_pkg::*;

    localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

    typedef struct packed {
        logic             rd;
        logic             wr;
        logic             err;
        logic [idx_w-1:0] idx;
    } pend_t;

    logic [31:0] mem [mem_words];
    pend_t       pend;
    logic        idle;
    logic        ar_hs;
    logic        wr_hs;
    logic        ar_in_range;
    logic        aw_in_range;
    logic        timer_done;
    logic [31:0] rdata_q;
    logic [1:0]  resp_q;
    logic        rvalid_q;
    logic        bvalid_q;

    assign idle        = ~pend.rd & ~pend.wr & ~rvalid_q & ~bvalid_q;
    assign ar_hs       = axm.arvalid & idle;
    // aw and w are taken in the same cycle
    assign wr_hs       = axm.awvalid & axm.wvalid & idle;
    assign ar_in_range = axm.araddr[31:2] < 30'(mem_words);
    assign aw_in_range = axm.awaddr[31:2] < 30'(mem_words);

    wait_timer #(
        .mem_wait(mem_wait)
    ) u_wait_timer (
        .clk  (clk),
        .rst_n(rst_n),
        .start(ar_hs | wr_hs),
        .done (timer_done)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend     <= '0;
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (ar_hs) begin
                pend.rd  <= 1'b1;
                pend.err <= ~ar_in_range;
                pend.idx <= axm.araddr[idx_w+1:2];
            end else if (wr_hs) begin
                pend.wr  <= 1'b1;
                pend.err <= ~aw_in_range;
            end else if (timer_done) begin
                pend.rd  <= 1'b0;
                pend.wr  <= 1'b0;
                rvalid_q <= pend.rd;
                bvalid_q <= pend.wr;
            end
            if (rvalid_q && axm.rready) begin
                rvalid_q <= 1'b0;
            end
            if (bvalid_q && axm.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (timer_done) begin
            resp_q  <= pend.err ? resp_slverr : resp_okay;
            rdata_q <= pend.err ? '0 : mem[pend.idx];
        end
    end

    // byte lanes written at accept, response follows after the wait
    always_ff @(posedge clk) begin
        if (wr_hs && aw_in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (axm.wstrb[b]) begin
                    mem[axm.awaddr[idx_w+1:2]][8*b +: 8] <= axm.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        axs.arready = idle;
        axs.rdata   = rdata_q;
        axs.rresp   = resp_q;
        axs.rvalid  = rvalid_q;
        axs.awready = idle;
        axs.wready  = idle;
        axs.bresp   = resp_q;
        axs.bvalid  = bvalid_q;
    end

endmodule

// File: rtl/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  logic [31:0] word,
    input  logic [1:0]  offset,
    input  logic [2:0]  funct3,
    output logic        misaligned,
    output logic [31:0] data
);
    import lsu_pkg::*;

    logic [31:0] shifted;

    // addressed byte down to lane 0
    assign shifted = word >> {offset, 3'b000};

    always_comb begin
        case (funct3)
            f3_b:    data = {{24{shifted[7]}}, shifted[7:0]};
            f3_bu:   data = {24'b0, shifted[7:0]};
            f3_h:    data = {{16{shifted[15]}}, shifted[15:0]};
            f3_hu:   data = {16'b0, shifted[15:0]};
            default: data = shifted;
        endcase
    end

    always_comb begin
        case (funct3)
            f3_b, f3_bu: misaligned = 1'b0;
            // halfword may not straddle the word
            f3_h, f3_hu: misaligned = (offset == 2'd3);
            default:     misaligned = (offset != 2'd0);
        endcase
    end

endmodule

// File: rtl/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              prev_valid,
    input  lsu_pkg::lsu_req_t req,
    output logic              this_ready,
    output logic              this_valid,
    input  logic              next_ready,
    output lsu_pkg::lsu_rsp_t rsp,
    output lsu_pkg::axil_m_t  axm,
    input  lsu_pkg::axil_s_t  axs
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_resp,
        st_done
    } state_t;

    state_t      state;
    lsu_req_t    req_q;
    lsu_req_t    cur;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [1:0]  offset;
    logic        is_load;
    logic        is_store;
    logic        ld_mis;
    logic        st_mis;
    logic        misaligned;
    logic        go_mem;
    logic        accept;
    logic [31:0] ld_data;
    logic [31:0] st_wdata;
    logic [3:0]  st_wstrb;
    logic        ar_hs;
    logic        aw_hs;
    logic        w_hs;
    logic        aw_done;
    logic        w_done;

    // incoming request while idle, the stored one afterwards
    assign cur    = (state == st_idle) ? req : req_q;
    assign opcode = cur.inst[6:0];
    assign funct3 = cur.inst[14:12];
    assign offset = cur.addr[1:0];

    assign is_load    = (opcode == opc_load);
    assign is_store   = (opcode == opc_store);
    assign misaligned = (is_load & ld_mis) | (is_store & st_mis);
    assign go_mem     = (is_load | is_store) & ~misaligned;

    assign this_ready = (state == st_idle);
    assign this_valid = (state == st_done);
    assign accept     = prev_valid & this_ready;

    assign ar_hs = axm.arvalid & axs.arready;
    assign aw_hs = axm.awvalid & axs.awready;
    assign w_hs  = axm.wvalid & axs.wready;

    load_align u_load_align (
        .word      (axs.rdata),
        .offset    (offset),
        .funct3    (funct3),
        .misaligned(ld_mis),
        .data      (ld_data)
    );

    store_align u_store_align (
        .wdata_in  (cur.wdata),
        .offset    (offset),
        .funct3    (funct3),
        .wdata     (st_wdata),
        .wstrb     (st_wstrb),
        .misaligned(st_mis)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= go_mem ? st_addr : st_done;
                    end
                end
                st_addr: begin
                    if (is_load) begin
                        if (ar_hs) begin
                            state <= st_resp;
                        end
                    end else begin
                        if (aw_hs) begin
                            aw_done <= 1'b1;
                        end
                        if (w_hs) begin
                            w_done <= 1'b1;
                        end
                        if ((aw_done | aw_hs) && (w_done | w_hs)) begin
                            state <= st_resp;
                        end
                    end
                end
                st_resp: begin
                    if ((is_load && axs.rvalid) || (is_store && axs.bvalid)) begin
                        state <= st_done;
                    end
                end
                default: begin
                    if (next_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q     <= req;
            rsp.rdata <= '0;
            rsp.err   <= misaligned;
        end
        if (state == st_resp) begin
            if (is_load && axs.rvalid) begin
                rsp.rdata <= ld_data;
                rsp.err   <= (axs.rresp != resp_okay);
            end else if (is_store && axs.bvalid) begin
                rsp.err <= (axs.bresp != resp_okay);
            end
        end
    end

    always_comb begin
        axm.araddr  = {req_q.addr[31:2], 2'b00};
        axm.arvalid = (state == st_addr) & is_load;
        axm.awaddr  = {req_q.addr[31:2], 2'b00};
        axm.awvalid = (state == st_addr) & is_store & ~aw_done;
        axm.wdata   = st_wdata;
        axm.wstrb   = st_wstrb;
        axm.wvalid  = (state == st_addr) & is_store & ~w_done;
        axm.rready  = (state == st_resp);
        axm.bready  = (state == st_resp);
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(axm.arvalid && axm.awvalid));

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axm.awvalid && !axs.awready |=> axm.awvalid);

endmodule

// File: rtl/lsu_pkg.sv
package lsu_pkg;

    // rv32i major opcodes
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;

    // access width codes
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } lsu_rsp_t;

    // master side of the axi-lite link
    typedef struct packed {
        logic [31:0] araddr;
        logic        arvalid;
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        rready;
        logic        bready;
    } axil_m_t;

    // slave side of the axi-lite link
    typedef struct packed {
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
    } axil_s_t;

endpackage

// File: rtl/lsu_subsys.sv
`timescale 1ns/1ps

module lsu_subsys #(
    parameter int mem_words = 256,
    parameter int mem_wait  = 3
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              prev_valid,
    input  lsu_pkg::lsu_req_t req,
    output logic              this_ready,
    output logic              this_valid,
    input  logic              next_ready,
    output lsu_pkg::lsu_rsp_t rsp
);
    import lsu_pkg::*;

    axil_m_t axm;
    axil_s_t axs;

    lsu_ctrl u_lsu_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .prev_valid(prev_valid),
        .req       (req),
        .this_ready(this_ready),
        .this_valid(this_valid),
        .next_ready(next_ready),
        .rsp       (rsp),
        .axm       (axm),
        .axs       (axs)
    );

    // data memory behind the unit
    axil_sram #(
        .mem_words(mem_words),
        .mem_wait (mem_wait)
    ) u_axil_sram (
        .clk  (clk),
        .rst_n(rst_n),
        .axm  (axm),
        .axs  (axs)
    );

endmodule

// File: rtl/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  logic [31:0] wdata_in,
    input  logic [1:0]  offset,
    input  logic [2:0]  funct3,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        misaligned
);
    import lsu_pkg::*;

    logic [7:0] mask;
    logic [7:0] lanes;

    always_comb begin
        case (funct3)
            f3_b:    mask = 8'b0000_0001;
            f3_h:    mask = 8'b0000_0011;
            f3_w:    mask = 8'b0000_1111;
            // illegal store width writes no lane
            default: mask = 8'b0000_0000;
        endcase
    end

    // 8 bits wide so a crossing strobe shows up in the upper half
    assign lanes      = mask << offset;
    assign wstrb      = lanes[3:0];
    assign misaligned = |lanes[7:4];
    assign wdata      = wdata_in << {offset, 3'b000};

endmodule

// File: rtl/wait_timer.sv
`timescale 1ns/1ps

module wait_timer #(
    parameter int mem_wait = 3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    localparam int cw = (mem_wait > 0) ? $clog2(mem_wait + 1) : 1;

    logic [cw-1:0] cnt;
    logic          busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= cw'(mem_wait);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign done = busy && (cnt == '0);

    // slave must not restart before the previous wait ran out
    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy);

endmodule

// File: vlog.f
rtl/lsu_pkg.sv
rtl/load_align.sv
rtl/store_align.sv
rtl/wait_timer.sv
rtl/axil_sram.sv
rtl/lsu_ctrl.sv
rtl/lsu_subsys.sv
dv/tb_lsu_subsys.sv
